/* source/rv_decode_pkg.sv */
package rv_decode_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5; // 32 architectural registers

	typedef logic [xlen-1:0]       word_t;
	typedef logic [xlen-1:0]       addr_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [31:0]           inst_t;
	typedef logic [6:0]            opcode_t;
	typedef logic [2:0]            funct3_t;

	// Major opcodes
	localparam opcode_t op_lui    = 7'b0110111;
	localparam opcode_t op_auipc  = 7'b0010111;
	localparam opcode_t op_jal    = 7'b1101111;
	localparam opcode_t op_jalr   = 7'b1100111;
	localparam opcode_t op_branch = 7'b1100011;
	localparam opcode_t op_load   = 7'b0000011;
	localparam opcode_t op_store  = 7'b0100011;
	localparam opcode_t op_opi    = 7'b0010011;
	localparam opcode_t op_op     = 7'b0110011;

	localparam funct3_t f3_beq  = 3'b000;
	localparam funct3_t f3_bne  = 3'b001;
	localparam funct3_t f3_blt  = 3'b100;
	localparam funct3_t f3_bge  = 3'b101;
	localparam funct3_t f3_bltu = 3'b110;
	localparam funct3_t f3_bgeu = 3'b111;

	localparam funct3_t f3_lb  = 3'b000;
	localparam funct3_t f3_lh  = 3'b001;
	localparam funct3_t f3_lw  = 3'b010;
	localparam funct3_t f3_lbu = 3'b100;
	localparam funct3_t f3_lhu = 3'b101;

	localparam funct3_t f3_sb = 3'b000;
	localparam funct3_t f3_sh = 3'b001;
	localparam funct3_t f3_sw = 3'b010;

	// Shared by OP and OP-IMM
	localparam funct3_t f3_add_sub = 3'b000;
	localparam funct3_t f3_sll     = 3'b001;
	localparam funct3_t f3_slt     = 3'b010;
	localparam funct3_t f3_sltu    = 3'b011;
	localparam funct3_t f3_xor     = 3'b100;
	localparam funct3_t f3_srl_sra = 3'b101;
	localparam funct3_t f3_or      = 3'b110;
	localparam funct3_t f3_and     = 3'b111;

	typedef enum logic [4:0] {
		alu_nop,
		alu_or, alu_and, alu_xor, alu_add, alu_sub,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra,
		alu_auipc, alu_jal, alu_jalr,
		alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
		alu_lb, alu_lh, alu_lw, alu_lbu, alu_lhu,
		alu_sb, alu_sh, alu_sw
	} alu_op_e;

	// Result class picked in EX
	typedef enum logic [2:0] {
		sel_nop,
		sel_logic,
		sel_arith,
		sel_shift,
		sel_jump_branch,
		sel_load_store
	} alu_sel_e;

endpackage

/* source/imm_gen.sv */
module imm_gen (
	input  rv_decode_pkg::inst_t     inst_i,
	output rv_decode_pkg::word_t     imm_o,
	output rv_decode_pkg::reg_addr_t rs1_o,
	output rv_decode_pkg::reg_addr_t rs2_o,
	output rv_decode_pkg::reg_addr_t rd_o
);

	rv_decode_pkg::opcode_t opcode;
	rv_decode_pkg::funct3_t funct3;
	rv_decode_pkg::word_t   imm_i_s; // Sign-extended I
	rv_decode_pkg::word_t   imm_i_z; // Zero-extended I, logic ops
	rv_decode_pkg::word_t   imm_sh;
	rv_decode_pkg::word_t   imm_s;
	rv_decode_pkg::word_t   imm_b;
	rv_decode_pkg::word_t   imm_u;
	rv_decode_pkg::word_t   imm_j;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign rd_o   = inst_i[11:7];
	assign rs1_o  = inst_i[19:15];
	assign rs2_o  = inst_i[24:20];

	assign imm_i_s = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_i_z = {20'h0, inst_i[31:20]};
	assign imm_sh  = {27'h0, inst_i[24:20]}; // shamt
	assign imm_s   = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b   = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u   = {inst_i[31:12], 12'h0};
	assign imm_j   = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb
	begin
		case (opcode)
			rv_decode_pkg::op_lui, rv_decode_pkg::op_auipc: imm_o = imm_u;
			rv_decode_pkg::op_jal:                          imm_o = imm_j;
			rv_decode_pkg::op_jalr, rv_decode_pkg::op_load: imm_o = imm_i_s;
			rv_decode_pkg::op_branch:                       imm_o = imm_b;
			rv_decode_pkg::op_store:                        imm_o = imm_s;
			rv_decode_pkg::op_opi:
			begin
				case (funct3)
					rv_decode_pkg::f3_xor, rv_decode_pkg::f3_or,
					rv_decode_pkg::f3_and:     imm_o = imm_i_z;
					rv_decode_pkg::f3_sll,
					rv_decode_pkg::f3_srl_sra: imm_o = imm_sh;
					default:                   imm_o = imm_i_s;
				endcase
			end
			default: imm_o = '0; // OP and unknown opcodes
		endcase
	end

endmodule

/* source/ctrl_decode.sv */
module ctrl_decode (
	input  rv_decode_pkg::inst_t    inst_i,
	output rv_decode_pkg::alu_op_e  alu_op_o,
	output rv_decode_pkg::alu_sel_e alu_sel_o,
	output logic                    rs1_en_o,
	output logic                    rs2_en_o,
	output logic                    wr_en_o
);

	rv_decode_pkg::opcode_t opcode;
	rv_decode_pkg::funct3_t funct3;
	logic                   alt; // funct7 bit 30
	logic                   is_op;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign alt    = inst_i[30];
	assign is_op  = (opcode == rv_decode_pkg::op_op);

	always_comb
	begin
		// Typical case reads rs1 and writes rd
		alu_op_o = rv_decode_pkg::alu_nop;
		rs1_en_o = 1'b1;
		rs2_en_o = 1'b0;
		wr_en_o  = 1'b1;

		case (opcode)
			rv_decode_pkg::op_lui:
			begin
				alu_op_o = rv_decode_pkg::alu_or; // imm | imm
				rs1_en_o = 1'b0;
			end
			rv_decode_pkg::op_auipc:
			begin
				alu_op_o = rv_decode_pkg::alu_auipc;
				rs1_en_o = 1'b0;
			end
			rv_decode_pkg::op_jal:
			begin
				alu_op_o = rv_decode_pkg::alu_jal;
				rs1_en_o = 1'b0;
			end
			rv_decode_pkg::op_jalr: alu_op_o = rv_decode_pkg::alu_jalr;
			rv_decode_pkg::op_branch:
			begin
				rs2_en_o = 1'b1;
				wr_en_o  = 1'b0;
				case (funct3)
					rv_decode_pkg::f3_beq:  alu_op_o = rv_decode_pkg::alu_beq;
					rv_decode_pkg::f3_bne:  alu_op_o = rv_decode_pkg::alu_bne;
					rv_decode_pkg::f3_blt:  alu_op_o = rv_decode_pkg::alu_blt;
					rv_decode_pkg::f3_bge:  alu_op_o = rv_decode_pkg::alu_bge;
					rv_decode_pkg::f3_bltu: alu_op_o = rv_decode_pkg::alu_bltu;
					rv_decode_pkg::f3_bgeu: alu_op_o = rv_decode_pkg::alu_bgeu;
					default:                alu_op_o = rv_decode_pkg::alu_nop;
				endcase
			end
			rv_decode_pkg::op_load:
			begin
				case (funct3)
					rv_decode_pkg::f3_lb:  alu_op_o = rv_decode_pkg::alu_lb;
					rv_decode_pkg::f3_lh:  alu_op_o = rv_decode_pkg::alu_lh;
					rv_decode_pkg::f3_lw:  alu_op_o = rv_decode_pkg::alu_lw;
					rv_decode_pkg::f3_lbu: alu_op_o = rv_decode_pkg::alu_lbu;
					rv_decode_pkg::f3_lhu: alu_op_o = rv_decode_pkg::alu_lhu;
					default:               alu_op_o = rv_decode_pkg::alu_nop;
				endcase
			end
			rv_decode_pkg::op_store:
			begin
				rs2_en_o = 1'b1;
				wr_en_o  = 1'b0;
				case (funct3)
					rv_decode_pkg::f3_sb: alu_op_o = rv_decode_pkg::alu_sb;
					rv_decode_pkg::f3_sh: alu_op_o = rv_decode_pkg::alu_sh;
					rv_decode_pkg::f3_sw: alu_op_o = rv_decode_pkg::alu_sw;
					default:              alu_op_o = rv_decode_pkg::alu_nop;
				endcase
			end
			rv_decode_pkg::op_opi, rv_decode_pkg::op_op:
			begin
				rs2_en_o = is_op; // OP-IMM takes the immediate instead
				case (funct3)
					rv_decode_pkg::f3_add_sub:
						alu_op_o = (alt && is_op) ? rv_decode_pkg::alu_sub : rv_decode_pkg::alu_add;
					rv_decode_pkg::f3_sll:  alu_op_o = rv_decode_pkg::alu_sll;
					rv_decode_pkg::f3_slt:  alu_op_o = rv_decode_pkg::alu_slt;
					rv_decode_pkg::f3_sltu: alu_op_o = rv_decode_pkg::alu_sltu;
					rv_decode_pkg::f3_xor:  alu_op_o = rv_decode_pkg::alu_xor;
					rv_decode_pkg::f3_srl_sra:
						alu_op_o = alt ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
					rv_decode_pkg::f3_or:   alu_op_o = rv_decode_pkg::alu_or;
					rv_decode_pkg::f3_and:  alu_op_o = rv_decode_pkg::alu_and;
					default:                alu_op_o = rv_decode_pkg::alu_nop;
				endcase
			end
			default: alu_op_o = rv_decode_pkg::alu_nop;
		endcase

		// Bubble on anything unmatched
		if (alu_op_o == rv_decode_pkg::alu_nop)
		begin
			rs1_en_o = 1'b0;
			rs2_en_o = 1'b0;
			wr_en_o  = 1'b0;
		end
	end

	// Result class follows the op, branches produce no result
	always_comb
	begin
		case (alu_op_o)
			rv_decode_pkg::alu_or, rv_decode_pkg::alu_and, rv_decode_pkg::alu_xor:
				alu_sel_o = rv_decode_pkg::sel_logic;
			rv_decode_pkg::alu_add, rv_decode_pkg::alu_sub, rv_decode_pkg::alu_slt,
			rv_decode_pkg::alu_sltu, rv_decode_pkg::alu_auipc:
				alu_sel_o = rv_decode_pkg::sel_arith;
			rv_decode_pkg::alu_sll, rv_decode_pkg::alu_srl, rv_decode_pkg::alu_sra:
				alu_sel_o = rv_decode_pkg::sel_shift;
			rv_decode_pkg::alu_jal, rv_decode_pkg::alu_jalr:
				alu_sel_o = rv_decode_pkg::sel_jump_branch;
			rv_decode_pkg::alu_lb, rv_decode_pkg::alu_lh, rv_decode_pkg::alu_lw,
			rv_decode_pkg::alu_lbu, rv_decode_pkg::alu_lhu, rv_decode_pkg::alu_sb,
			rv_decode_pkg::alu_sh, rv_decode_pkg::alu_sw:
				alu_sel_o = rv_decode_pkg::sel_load_store;
			default:
				alu_sel_o = rv_decode_pkg::sel_nop;
		endcase
	end

endmodule

/* source/operand_fwd.sv */
module operand_fwd (
	input  logic                     rd_en_i,
	input  rv_decode_pkg::reg_addr_t rd_addr_i,
	input  rv_decode_pkg::word_t     reg_data_i,
	input  rv_decode_pkg::word_t     imm_i,
	input  logic                     ex_load_pending_i,
	input  logic                     ex_wr_en_i,
	input  rv_decode_pkg::reg_addr_t ex_wr_addr_i,
	input  rv_decode_pkg::word_t     ex_wr_data_i,
	input  logic                     mem_wr_en_i,
	input  rv_decode_pkg::reg_addr_t mem_wr_addr_i,
	input  rv_decode_pkg::word_t     mem_wr_data_i,
	output rv_decode_pkg::word_t     operand_o,
	output logic                     stall_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = (ex_wr_addr_i == rd_addr_i);
	assign mem_hit = (mem_wr_addr_i == rd_addr_i);

	// Load data not back until after EX
	assign stall_o = rd_en_i && ex_load_pending_i && ex_hit;

	always_comb
	begin
		if (!rd_en_i)
			operand_o = imm_i;
		else if (ex_wr_en_i && ex_hit)
			operand_o = ex_wr_data_i; // Youngest result wins
		else if (mem_wr_en_i && mem_hit)
			operand_o = mem_wr_data_i;
		else
			operand_o = reg_data_i;
	end

endmodule

/* source/branch_resolve.sv */
module branch_resolve (
	input  rv_decode_pkg::alu_op_e alu_op_i,
	input  rv_decode_pkg::addr_t   pc_i,
	input  rv_decode_pkg::word_t   op1_i,
	input  rv_decode_pkg::word_t   op2_i,
	input  rv_decode_pkg::word_t   imm_i,
	output logic                   taken_o,
	output rv_decode_pkg::addr_t   target_o
);

	logic                 is_signed;
	logic                 eq;
	logic                 lt;
	rv_decode_pkg::addr_t pc_target;
	rv_decode_pkg::addr_t jalr_target;

	assign is_signed = (alu_op_i == rv_decode_pkg::alu_blt) ||
		(alu_op_i == rv_decode_pkg::alu_bge);

	assign eq = (op1_i == op2_i);
	assign lt = is_signed ? ($signed(op1_i) < $signed(op2_i)) : (op1_i < op2_i);

	assign pc_target   = pc_i + imm_i;
	assign jalr_target = op1_i + imm_i; // Bit 0 left as computed

	always_comb
	begin
		case (alu_op_i)
			rv_decode_pkg::alu_jal,
			rv_decode_pkg::alu_jalr: taken_o = 1'b1;
			rv_decode_pkg::alu_beq:  taken_o = eq;
			rv_decode_pkg::alu_bne:  taken_o = !eq;
			rv_decode_pkg::alu_blt,
			rv_decode_pkg::alu_bltu: taken_o = lt;
			rv_decode_pkg::alu_bge,
			rv_decode_pkg::alu_bgeu: taken_o = !lt;
			default:                 taken_o = 1'b0;
		endcase
	end

	always_comb
	begin
		if (!taken_o)
			target_o = '0;
		else if (alu_op_i == rv_decode_pkg::alu_jalr)
			target_o = jalr_target;
		else
			target_o = pc_target;
	end

endmodule

/* source/id_stage.sv */
module id_stage (
	input  logic                      clk,
	input  logic                      rst,

	input  logic                      in_valid_i,
	output logic                      in_ready_o,
	input  rv_decode_pkg::inst_t      inst_i,
	input  rv_decode_pkg::addr_t      pc_i,

	// Register file, answers in the same cycle
	output logic                      rs1_en_o,
	output logic                      rs2_en_o,
	output rv_decode_pkg::reg_addr_t  rs1_addr_o,
	output rv_decode_pkg::reg_addr_t  rs2_addr_o,
	input  rv_decode_pkg::word_t      rs1_data_i,
	input  rv_decode_pkg::word_t      rs2_data_i,

	input  logic                      ex_load_pending_i,
	input  logic                      ex_wr_en_i,
	input  rv_decode_pkg::reg_addr_t  ex_wr_addr_i,
	input  rv_decode_pkg::word_t      ex_wr_data_i,
	input  logic                      mem_wr_en_i,
	input  rv_decode_pkg::reg_addr_t  mem_wr_addr_i,
	input  rv_decode_pkg::word_t      mem_wr_data_i,

	// ID/EX latch
	output logic                      out_valid_o,
	input  logic                      out_ready_i,
	output rv_decode_pkg::alu_op_e    out_alu_op_o,
	output rv_decode_pkg::alu_sel_e   out_alu_sel_o,
	output rv_decode_pkg::word_t      out_op1_o,
	output rv_decode_pkg::word_t      out_op2_o,
	output rv_decode_pkg::word_t      out_offset_o,
	output logic                      out_wr_en_o,
	output rv_decode_pkg::reg_addr_t  out_wr_addr_o,
	output rv_decode_pkg::addr_t      out_pc_o,
	output logic                      out_branch_taken_o,
	output rv_decode_pkg::addr_t      out_branch_target_o
);

	rv_decode_pkg::word_t      imm;
	rv_decode_pkg::reg_addr_t  rd;
	rv_decode_pkg::alu_op_e    alu_op;
	rv_decode_pkg::alu_sel_e   alu_sel;
	logic                      wr_en;
	rv_decode_pkg::word_t      op1;
	rv_decode_pkg::word_t      op2;
	logic                      stall1;
	logic                      stall2;
	logic                      taken;
	rv_decode_pkg::addr_t      target;
	logic                      accept;

	imm_gen u_imm_gen (
		.inst_i (inst_i),
		.imm_o  (imm),
		.rs1_o  (rs1_addr_o),
		.rs2_o  (rs2_addr_o),
		.rd_o   (rd)
	);

	ctrl_decode u_ctrl_decode (
		.inst_i    (inst_i),
		.alu_op_o  (alu_op),
		.alu_sel_o (alu_sel),
		.rs1_en_o  (rs1_en_o),
		.rs2_en_o  (rs2_en_o),
		.wr_en_o   (wr_en)
	);

	operand_fwd u_fwd1 (
		.rd_en_i           (rs1_en_o),
		.rd_addr_i         (rs1_addr_o),
		.reg_data_i        (rs1_data_i),
		.imm_i             (imm),
		.ex_load_pending_i (ex_load_pending_i),
		.ex_wr_en_i        (ex_wr_en_i),
		.ex_wr_addr_i      (ex_wr_addr_i),
		.ex_wr_data_i      (ex_wr_data_i),
		.mem_wr_en_i       (mem_wr_en_i),
		.mem_wr_addr_i     (mem_wr_addr_i),
		.mem_wr_data_i     (mem_wr_data_i),
		.operand_o         (op1),
		.stall_o           (stall1)
	);

	operand_fwd u_fwd2 (
		.rd_en_i           (rs2_en_o),
		.rd_addr_i         (rs2_addr_o),
		.reg_data_i        (rs2_data_i),
		.imm_i             (imm),
		.ex_load_pending_i (ex_load_pending_i),
		.ex_wr_en_i        (ex_wr_en_i),
		.ex_wr_addr_i      (ex_wr_addr_i),
		.ex_wr_data_i      (ex_wr_data_i),
		.mem_wr_en_i       (mem_wr_en_i),
		.mem_wr_addr_i     (mem_wr_addr_i),
		.mem_wr_data_i     (mem_wr_data_i),
		.operand_o         (op2),
		.stall_o           (stall2)
	);

	branch_resolve u_branch (
		.alu_op_i (alu_op),
		.pc_i     (pc_i),
		.op1_i    (op1),
		.op2_i    (op2),
		.imm_i    (imm),
		.taken_o  (taken),
		.target_o (target)
	);

	// Latch free or draining, and no load-use hazard
	assign in_ready_o = (!out_valid_o || out_ready_i) && !(stall1 || stall2);
	assign accept     = in_valid_i && in_ready_o;

	always_ff @(posedge clk)
	begin
		if (rst)
			out_valid_o <= 1'b0;
		else if (accept)
			out_valid_o <= 1'b1;
		else if (out_ready_i)
			out_valid_o <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_alu_op_o        <= alu_op;
			out_alu_sel_o       <= alu_sel;
			out_op1_o           <= op1;
			out_op2_o           <= op2;
			out_offset_o        <= imm;
			out_wr_en_o         <= wr_en;
			out_wr_addr_o       <= rd;
			out_pc_o            <= pc_i;
			out_branch_taken_o  <= taken;
			out_branch_target_o <= target;
		end
	end

endmodule

/* test/id_stage_sva.sv */
module id_stage_sva (
	input logic                     clk,
	input logic                     rst,
	input logic                     in_ready_o,
	input logic                     rs1_en_o,
	input logic                     rs2_en_o,
	input rv_decode_pkg::reg_addr_t rs1_addr_o,
	input rv_decode_pkg::reg_addr_t rs2_addr_o,
	input logic                     ex_load_pending_i,
	input rv_decode_pkg::reg_addr_t ex_wr_addr_i,
	input logic                     out_valid_o,
	input logic                     out_ready_i,
	input rv_decode_pkg::alu_op_e   out_alu_op_o,
	input rv_decode_pkg::alu_sel_e  out_alu_sel_o,
	input rv_decode_pkg::word_t     out_op1_o,
	input rv_decode_pkg::word_t     out_op2_o,
	input rv_decode_pkg::word_t     out_offset_o,
	input logic                     out_wr_en_o,
	input rv_decode_pkg::reg_addr_t out_wr_addr_o,
	input rv_decode_pkg::addr_t     out_pc_o,
	input logic                     out_branch_taken_o,
	input rv_decode_pkg::addr_t     out_branch_target_o
);
	timeunit 1ns;
	timeprecision 1ps;

	logic hazard;

	assign hazard = (rs1_en_o && ex_load_pending_i && (ex_wr_addr_i == rs1_addr_o)) ||
		(rs2_en_o && ex_load_pending_i && (ex_wr_addr_i == rs2_addr_o));

	a_reset_clears: assert property (@(posedge clk) rst |=> !out_valid_o)
		else $error("out_valid_o high in the cycle after reset");

	a_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable({out_alu_op_o, out_alu_sel_o,
		out_op1_o, out_op2_o, out_offset_o, out_wr_en_o, out_wr_addr_o, out_pc_o,
		out_branch_taken_o, out_branch_target_o}))
		else $error("Output bundle changed under back-pressure");

	a_stall: assert property (@(posedge clk) disable iff (rst) hazard |-> !in_ready_o)
		else $error("in_ready_o high during a load-use hazard");

endmodule

bind id_stage id_stage_sva u_sva (.*);

/* test/tb_id_stage.sv */
module tb_id_stage;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [4:0]  op;
		logic [2:0]  sel;
		logic        rs1_en;
		logic        rs2_en;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] off;
		logic        wr_en;
		logic [4:0]  wr_addr;
		logic [31:0] pc;
		logic        taken;
		logic [31:0] target;
	} exp_t;

	logic clk, rst, in_valid_i, in_ready_o, out_valid_o, out_ready_i;
	logic rs1_en_o, rs2_en_o, ex_load_pending_i, ex_wr_en_i, mem_wr_en_i;
	logic out_wr_en_o, out_branch_taken_o;
	rv_decode_pkg::inst_t     inst_i;
	rv_decode_pkg::addr_t     pc_i, out_pc_o, out_branch_target_o;
	rv_decode_pkg::reg_addr_t rs1_addr_o, rs2_addr_o, ex_wr_addr_i, mem_wr_addr_i;
	rv_decode_pkg::reg_addr_t out_wr_addr_o;
	rv_decode_pkg::word_t     rs1_data_i, rs2_data_i, ex_wr_data_i, mem_wr_data_i;
	rv_decode_pkg::word_t     out_op1_o, out_op2_o, out_offset_o;
	rv_decode_pkg::alu_op_e   out_alu_op_o;
	rv_decode_pkg::alu_sel_e  out_alu_sel_o;

	integer               seed = 80;
	string                test_name = "reset";
	logic                 bp_mode = 1'b0;
	logic                 full_rate = 1'b0;
	int                   cycles = 0;
	exp_t                 exp_q[$];
	rv_decode_pkg::word_t regs [32];

	id_stage dut (.*);

	assign rs1_data_i = regs[rs1_addr_o]; // Same-cycle register file
	assign rs2_data_i = regs[rs2_addr_o];

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	function automatic rv_decode_pkg::word_t pick_src(input logic en, input logic [4:0] a,
		input rv_decode_pkg::word_t imm);
		if (!en)
			return imm;
		if (ex_wr_en_i && ex_wr_addr_i == a)
			return ex_wr_data_i;
		if (mem_wr_en_i && mem_wr_addr_i == a)
			return mem_wr_data_i;
		return regs[a];
	endfunction

	function automatic exp_t ref_decode(input logic [31:0] inst, input logic [31:0] pc);
		exp_t                   e;
		rv_decode_pkg::alu_op_e op;
		logic [2:0]             f3;
		logic                   r1;
		logic                   r2;
		logic [31:0]            imm;
		logic [31:0]            si;
		f3 = inst[14:12];
		si = {{20{inst[31]}}, inst[31:20]};
		op = rv_decode_pkg::alu_nop;
		r1 = 1'b1;
		r2 = 1'b0;
		e.wr_en = 1'b1;
		imm = '0;
		case (inst[6:0])
			rv_decode_pkg::op_lui:
			begin
				op = rv_decode_pkg::alu_or;
				r1 = 1'b0;
				imm = {inst[31:12], 12'h0};
			end
			rv_decode_pkg::op_auipc:
			begin
				op = rv_decode_pkg::alu_auipc;
				r1 = 1'b0;
				imm = {inst[31:12], 12'h0};
			end
			rv_decode_pkg::op_jal:
			begin
				op = rv_decode_pkg::alu_jal;
				r1 = 1'b0;
				imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			rv_decode_pkg::op_jalr:
			begin
				op = rv_decode_pkg::alu_jalr;
				imm = si;
			end
			rv_decode_pkg::op_branch:
			begin
				r2 = 1'b1;
				e.wr_en = 1'b0;
				imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
				case (f3)
					3'd0: op = rv_decode_pkg::alu_beq;
					3'd1: op = rv_decode_pkg::alu_bne;
					3'd4: op = rv_decode_pkg::alu_blt;
					3'd5: op = rv_decode_pkg::alu_bge;
					3'd6: op = rv_decode_pkg::alu_bltu;
					3'd7: op = rv_decode_pkg::alu_bgeu;
					default: op = rv_decode_pkg::alu_nop;
				endcase
			end
			rv_decode_pkg::op_load:
			begin
				imm = si;
				case (f3)
					3'd0: op = rv_decode_pkg::alu_lb;
					3'd1: op = rv_decode_pkg::alu_lh;
					3'd2: op = rv_decode_pkg::alu_lw;
					3'd4: op = rv_decode_pkg::alu_lbu;
					3'd5: op = rv_decode_pkg::alu_lhu;
					default: op = rv_decode_pkg::alu_nop;
				endcase
			end
			rv_decode_pkg::op_store:
			begin
				r2 = 1'b1;
				e.wr_en = 1'b0;
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
				case (f3)
					3'd0: op = rv_decode_pkg::alu_sb;
					3'd1: op = rv_decode_pkg::alu_sh;
					3'd2: op = rv_decode_pkg::alu_sw;
					default: op = rv_decode_pkg::alu_nop;
				endcase
			end
			rv_decode_pkg::op_opi, rv_decode_pkg::op_op:
			begin
				r2 = (inst[6:0] == rv_decode_pkg::op_op);
				if (!r2)
					imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'h0, inst[24:20]} :
						(f3 == 3'd4 || f3 == 3'd6 || f3 == 3'd7) ? {20'h0, inst[31:20]} : si;
				case (f3)
					3'd0: op = (r2 && inst[30]) ? rv_decode_pkg::alu_sub : rv_decode_pkg::alu_add;
					3'd1: op = rv_decode_pkg::alu_sll;
					3'd2: op = rv_decode_pkg::alu_slt;
					3'd3: op = rv_decode_pkg::alu_sltu;
					3'd4: op = rv_decode_pkg::alu_xor;
					3'd5: op = inst[30] ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
					3'd6: op = rv_decode_pkg::alu_or;
					default: op = rv_decode_pkg::alu_and;
				endcase
			end
			default: op = rv_decode_pkg::alu_nop;
		endcase
		if (op == rv_decode_pkg::alu_nop)
		begin
			r1 = 1'b0;
			r2 = 1'b0;
			e.wr_en = 1'b0;
		end
		e.op = op;
		e.rs1_en = r1;
		e.rs2_en = r2;
		e.op1 = pick_src(r1, inst[19:15], imm);
		e.op2 = pick_src(r2, inst[24:20], imm);
		e.off = imm;
		e.wr_addr = inst[11:7];
		e.pc = pc;
		case (op)
			rv_decode_pkg::alu_or, rv_decode_pkg::alu_and, rv_decode_pkg::alu_xor:
				e.sel = rv_decode_pkg::sel_logic;
			rv_decode_pkg::alu_add, rv_decode_pkg::alu_sub, rv_decode_pkg::alu_slt,
			rv_decode_pkg::alu_sltu, rv_decode_pkg::alu_auipc:
				e.sel = rv_decode_pkg::sel_arith;
			rv_decode_pkg::alu_sll, rv_decode_pkg::alu_srl, rv_decode_pkg::alu_sra:
				e.sel = rv_decode_pkg::sel_shift;
			rv_decode_pkg::alu_jal, rv_decode_pkg::alu_jalr:
				e.sel = rv_decode_pkg::sel_jump_branch;
			rv_decode_pkg::alu_lb, rv_decode_pkg::alu_lh, rv_decode_pkg::alu_lw,
			rv_decode_pkg::alu_lbu, rv_decode_pkg::alu_lhu, rv_decode_pkg::alu_sb,
			rv_decode_pkg::alu_sh, rv_decode_pkg::alu_sw:
				e.sel = rv_decode_pkg::sel_load_store;
			default: e.sel = rv_decode_pkg::sel_nop; // Branches carry no result
		endcase
		case (op)
			rv_decode_pkg::alu_jal, rv_decode_pkg::alu_jalr: e.taken = 1'b1;
			rv_decode_pkg::alu_beq:  e.taken = (e.op1 == e.op2);
			rv_decode_pkg::alu_bne:  e.taken = (e.op1 != e.op2);
			rv_decode_pkg::alu_blt:  e.taken = ($signed(e.op1) < $signed(e.op2));
			rv_decode_pkg::alu_bge:  e.taken = ($signed(e.op1) >= $signed(e.op2));
			rv_decode_pkg::alu_bltu: e.taken = (e.op1 < e.op2);
			rv_decode_pkg::alu_bgeu: e.taken = (e.op1 >= e.op2);
			default: e.taken = 1'b0;
		endcase
		if (!e.taken)
			e.target = '0;
		else if (op == rv_decode_pkg::alu_jalr)
			e.target = e.op1 + si;
		else
			e.target = pc + imm;
		return e;
	endfunction

	function automatic logic [31:0] rand_inst(input int kind);
		logic [31:0] r;
		r = $random(seed);
		case (kind)
			0:
			begin
				r[6:0] = rv_decode_pkg::op_op;
				r[31:25] = r[31] ? 7'h20 : 7'h00;
			end
			1:
			begin
				r[6:0] = rv_decode_pkg::op_opi;
				if (r[14:12] == 3'd1)
					r[31:25] = 7'h00;
				if (r[14:12] == 3'd5)
					r[31:25] = r[31] ? 7'h20 : 7'h00;
			end
			2: r[6:0] = rv_decode_pkg::op_load;
			3: r[6:0] = rv_decode_pkg::op_store;
			4: r[6:0] = r[5] ? rv_decode_pkg::op_lui : rv_decode_pkg::op_auipc;
			5:
			begin
				r[6:0] = rv_decode_pkg::op_branch;
				r[19:17] = 3'b000; // Edge-value registers 0..3
				r[24:22] = 3'b000;
			end
			6: r[6:0] = r[5] ? rv_decode_pkg::op_jal : rv_decode_pkg::op_jalr;
			default: r[6:0] = 7'b0001011; // Custom opcode outside the decoder
		endcase
		return r;
	endfunction

	task automatic send(input logic [31:0] inst);
		logic [31:0] r;
		r = $random(seed);
		inst_i <= inst;
		pc_i <= $random(seed);
		in_valid_i <= 1'b1;
		ex_load_pending_i <= 1'b0;
		ex_wr_en_i <= r[0];
		mem_wr_en_i <= r[1];
		ex_wr_addr_i <= r[2] ? inst[19:15] : inst[24:20];
		mem_wr_addr_i <= r[3] ? inst[19:15] : r[8:4];
		ex_wr_data_i <= $random(seed);
		mem_wr_data_i <= $random(seed);
		@(posedge clk);
		if (full_rate)
		begin
			assert (in_ready_o)
			else report_failure("in_ready_o dropped with both handshakes held high");
		end
		while (!in_ready_o)
			@(posedge clk);
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			in_valid_i <= 1'b0;
			@(posedge clk);
		end
	endtask

	task automatic check_field(input string field, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		assert (exp_v === act_v)
		else
		begin
			$display("[ERROR] %s %s expected %h actual %h", test_name, field, exp_v, act_v);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	// Read requests are combinational, so they are checked at acceptance
	always @(posedge clk)
	begin : accept_check
		exp_t e;
		if (!rst && in_valid_i && in_ready_o)
		begin
			e = ref_decode(inst_i, pc_i);
			check_field("rs1_en", 32'(e.rs1_en), 32'(rs1_en_o));
			check_field("rs2_en", 32'(e.rs2_en), 32'(rs2_en_o));
			check_field("rs1_addr", 32'(inst_i[19:15]), 32'(rs1_addr_o));
			check_field("rs2_addr", 32'(inst_i[24:20]), 32'(rs2_addr_o));
			exp_q.push_back(e);
		end
	end

	always @(posedge clk)
	begin : compare
		exp_t e;
		if (!rst && out_valid_o && out_ready_i)
		begin
			assert (exp_q.size() > 0)
			else report_failure("Output transfer with no accepted instruction pending");
			e = exp_q.pop_front();
			check_field("alu_op", 32'(e.op), 32'(out_alu_op_o));
			check_field("alu_sel", 32'(e.sel), 32'(out_alu_sel_o));
			check_field("op1", e.op1, out_op1_o);
			check_field("op2", e.op2, out_op2_o);
			check_field("offset", e.off, out_offset_o);
			check_field("wr_en", 32'(e.wr_en), 32'(out_wr_en_o));
			check_field("wr_addr", 32'(e.wr_addr), 32'(out_wr_addr_o));
			check_field("pc", e.pc, out_pc_o);
			check_field("taken", 32'(e.taken), 32'(out_branch_taken_o));
			check_field("target", e.target, out_branch_target_o);
		end
	end

	always @(posedge clk)
	begin : ready_gen
		logic [31:0] r;
		r = $random(seed);
		out_ready_i <= bp_mode ? r[0] : 1'b1;
		cycles <= cycles + 1;
		if (cycles >= 2000) // About four times the test length
			report_failure("Timeout, the run did not finish within 2000 cycles");
	end

	initial
	begin
		logic [31:0] r;
		rst = 1'b1;
		in_valid_i = 1'b0;
		out_ready_i = 1'b1;
		inst_i = '0;
		pc_i = '0;
		ex_load_pending_i = 1'b0;
		ex_wr_en_i = 1'b0;
		ex_wr_addr_i = '0;
		ex_wr_data_i = '0;
		mem_wr_en_i = 1'b0;
		mem_wr_addr_i = '0;
		mem_wr_data_i = '0;
		for (int i = 0; i < 32; i++)
			regs[i] = $random(seed);
		regs[0] = 32'h0000_0000; // Signed and unsigned edges
		regs[1] = 32'h8000_0000;
		regs[2] = 32'h7fff_ffff;
		regs[3] = 32'hffff_ffff;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		test_name = "decode";
		for (int i = 0; i < 160; i++)
		begin
			r = $random(seed);
			send(rand_inst(i % 8));
			idle(int'(r[0]));
		end
		idle(2);

		test_name = "load_use";
		inst_i <= {7'h00, 5'd9, 5'd5, 3'b000, 5'd7, rv_decode_pkg::op_op};
		in_valid_i <= 1'b1;
		ex_load_pending_i <= 1'b1;
		ex_wr_en_i <= 1'b1;
		ex_wr_addr_i <= 5'd5;
		repeat (5)
		begin
			@(posedge clk);
			assert (!in_ready_o)
			else report_failure("Instruction accepted during a load-use hazard");
		end
		ex_load_pending_i <= 1'b0;
		@(posedge clk);
		while (!in_ready_o)
			@(posedge clk);
		idle(2);

		test_name = "backpressure";
		bp_mode <= 1'b1;
		for (int i = 0; i < 100; i++)
		begin
			r = $random(seed);
			send(rand_inst(int'(r[2:0])));
			idle(int'(r[4:3]) % 3);
		end
		bp_mode <= 1'b0;
		idle(3);

		test_name = "throughput";
		full_rate = 1'b1;
		for (int i = 0; i < 40; i++)
			send(rand_inst(i % 8));
		full_rate = 1'b0;
		idle(4);

		if (exp_q.size() == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
			report_failure("Accepted instructions never appeared on the output");
	end

endmodule

/* project.f */
source/rv_decode_pkg.sv
source/imm_gen.sv
source/ctrl_decode.sv
source/operand_fwd.sv
source/branch_resolve.sv
source/id_stage.sv
test/id_stage_sva.sv
test/tb_id_stage.sv

/* run.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert -f project.f --top-module tb_id_stage -Mdir obj_dir

./obj_dir/Vtb_id_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
